//--- rtl/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Entries in the instruction buffer between decode and the scoreboard
`define ISSUE_IBUF_DEPTH 4

// Architectural registers, register 0 is hardwired to zero
`define ISSUE_NUM_REGS 32

// Width of register data and of the dispatched immediate
`define ISSUE_XLEN 32

`endif

//--- rtl/issue_pkg.sv
package issue_pkg;

    // Target execution unit of an instruction
    typedef enum logic [0:0] {
        EX_ALU = 1'b0,
        EX_LSU = 1'b1
    } ex_type_e;

    typedef logic [4:0] reg_idx_t;

    // Register form, second source is a register
    typedef struct packed {
        ex_type_e   ex_type;
        logic       use_imm;
        logic [3:0] op;
        reg_idx_t   rd;
        logic       wb;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [9:0] pad;
    } instr_reg_t;

    // Immediate form, the low 15 bits carry the immediate
    typedef struct packed {
        ex_type_e    ex_type;
        logic        use_imm;
        logic [3:0]  op;
        reg_idx_t    rd;
        logic        wb;
        reg_idx_t    rs1;
        logic [14:0] imm;
    } instr_imm_t;

    // The leading 17 bits are common to both views and use_imm picks the tail
    typedef union packed {
        instr_reg_t reg_form;
        instr_imm_t imm_form;
    } instr_t;

endpackage

//--- rtl/issue_ibuffer.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_ibuffer (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              decode_valid,
    input  issue_pkg::instr_t decode_instr,
    output logic              decode_ready,
    output logic              ibuf_valid,
    output issue_pkg::instr_t ibuf_instr,
    input  logic              ibuf_ready
);
    import issue_pkg::*;

    localparam int DEPTH = `ISSUE_IBUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    instr_t           entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign decode_ready = (count != CNT_W'(DEPTH));
    assign push         = decode_valid && decode_ready;
    assign pop          = ibuf_valid && ibuf_ready;

    // The head is read straight from the storage flops
    assign ibuf_valid = (count != '0);
    assign ibuf_instr = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= decode_instr;
        end
    end

    // A flush drops everything held, including a push in the same cycle
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/issue_scoreboard.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_scoreboard (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                ibuf_valid,
    input  issue_pkg::instr_t   ibuf_instr,
    output logic                ibuf_ready,
    output logic                sb_valid,
    output issue_pkg::instr_t   sb_instr,
    input  logic                sb_ready,
    input  logic                wb_valid,
    input  issue_pkg::reg_idx_t wb_rd
);
    import issue_pkg::*;

    localparam int NREGS = `ISSUE_NUM_REGS;

    logic [NREGS-1:0] pending;
    logic [NREGS-1:0] pending_next;
    logic [NREGS-1:0] live;
    reg_idx_t         head_rs1;
    reg_idx_t         head_rs2;
    reg_idx_t         head_rd;
    logic             rs1_busy;
    logic             rs2_busy;
    logic             rd_busy;
    logic             hazard;
    logic             issue_fire;

    // rs1 and rd sit in the shared part of the word
    assign head_rs1 = ibuf_instr.reg_form.rs1;
    assign head_rs2 = ibuf_instr.reg_form.rs2;
    assign head_rd  = ibuf_instr.reg_form.rd;

    // A writeback arriving this cycle already releases its register
    always_comb begin
        live = pending;
        if (wb_valid) begin
            live[wb_rd] = 1'b0;
        end
    end

    // In the immediate form the rs2 bits belong to the immediate
    assign rs1_busy = live[head_rs1];
    assign rs2_busy = !ibuf_instr.reg_form.use_imm && live[head_rs2];
    assign rd_busy  = ibuf_instr.reg_form.wb && live[head_rd];
    assign hazard   = rs1_busy || rs2_busy || rd_busy;

    assign sb_valid   = ibuf_valid && !hazard;
    assign ibuf_ready = sb_ready && !hazard;
    assign sb_instr   = ibuf_instr;
    assign issue_fire = sb_valid && sb_ready;

    // Set after clear so that a new owner of the same register wins
    always_comb begin
        pending_next = live;
        if (issue_fire && ibuf_instr.reg_form.wb && head_rd != '0) begin
            pending_next[head_rd] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

endmodule

//--- rtl/issue_operands.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_operands (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   sb_valid,
    input  issue_pkg::instr_t      sb_instr,
    output logic                   sb_ready,
    input  logic                   wb_valid,
    input  issue_pkg::reg_idx_t    wb_rd,
    input  logic [`ISSUE_XLEN-1:0] wb_data,
    output logic                   opd_valid,
    output issue_pkg::instr_t      opd_instr,
    output logic [`ISSUE_XLEN-1:0] opd_rs1_data,
    output logic [`ISSUE_XLEN-1:0] opd_rs2_data,
    input  logic                   opd_ready
);
    import issue_pkg::*;

    localparam int NREGS = `ISSUE_NUM_REGS;
    localparam int XLEN  = `ISSUE_XLEN;

    logic [XLEN-1:0] rf [NREGS];
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic            load;

    // Register 0 reads zero, a matching writeback in this cycle is forwarded
    function automatic logic [XLEN-1:0] read_reg(input reg_idx_t idx);
        logic [XLEN-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb_valid && wb_rd == idx) begin
            value = wb_data;
        end else begin
            value = rf[idx];
        end
        return value;
    endfunction

    // Architectural state starts at zero; later writebacks land even after a flush
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NREGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wb_valid && wb_rd != '0) begin
            rf[wb_rd] <= wb_data;
        end
    end

    assign rs1_val = read_reg(sb_instr.reg_form.rs1);
    assign rs2_val = sb_instr.reg_form.use_imm ? '0 : read_reg(sb_instr.reg_form.rs2);

    // Take a new instruction when empty or when the current one leaves
    assign sb_ready = !opd_valid || opd_ready;
    assign load     = sb_valid && sb_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            opd_valid <= 1'b0;
        end else if (load) begin
            opd_valid <= 1'b1;
        end else if (opd_ready) begin
            opd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opd_instr    <= sb_instr;
            opd_rs1_data <= rs1_val;
            opd_rs2_data <= rs2_val;
        end
    end

endmodule

//--- rtl/issue_dispatch.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_dispatch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   opd_valid,
    input  issue_pkg::instr_t      opd_instr,
    input  logic [`ISSUE_XLEN-1:0] opd_rs1_data,
    input  logic [`ISSUE_XLEN-1:0] opd_rs2_data,
    output logic                   opd_ready,
    input  logic                   alu_ready,
    input  logic                   lsu_ready,
    output logic                   alu_valid,
    output logic                   lsu_valid,
    output logic [3:0]             disp_op,
    output issue_pkg::reg_idx_t    disp_rd,
    output logic                   disp_wb,
    output logic [`ISSUE_XLEN-1:0] disp_rs1_data,
    output logic [`ISSUE_XLEN-1:0] disp_rs2_data,
    output logic [`ISSUE_XLEN-1:0] disp_imm
);
    import issue_pkg::*;

    localparam int XLEN = `ISSUE_XLEN;

    logic            disp_valid;
    ex_type_e        disp_ex;
    logic            unit_ready;
    logic            load;
    logic [XLEN-1:0] imm_ext;

    // The immediate is sign extended, the register form carries none
    assign imm_ext = opd_instr.imm_form.use_imm
                   ? {{(XLEN - 15){opd_instr.imm_form.imm[14]}}, opd_instr.imm_form.imm}
                   : '0;

    assign alu_valid  = disp_valid && (disp_ex == EX_ALU);
    assign lsu_valid  = disp_valid && (disp_ex == EX_LSU);
    assign unit_ready = (disp_ex == EX_ALU) ? alu_ready : lsu_ready;

    // Only the targeted unit can drain the output register
    assign opd_ready = !disp_valid || unit_ready;
    assign load      = opd_valid && opd_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            disp_valid <= 1'b0;
        end else if (load) begin
            disp_valid <= 1'b1;
        end else if (unit_ready) begin
            disp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            disp_ex       <= opd_instr.reg_form.ex_type;
            disp_op       <= opd_instr.reg_form.op;
            disp_rd       <= opd_instr.reg_form.rd;
            disp_wb       <= opd_instr.reg_form.wb;
            disp_rs1_data <= opd_rs1_data;
            disp_rs2_data <= opd_rs2_data;
            disp_imm      <= imm_ext;
        end
    end

endmodule

//--- rtl/issue_top.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   decode_valid,
    input  issue_pkg::instr_t      decode_instr,
    output logic                   decode_ready,
    input  logic                   wb_valid,
    input  issue_pkg::reg_idx_t    wb_rd,
    input  logic [`ISSUE_XLEN-1:0] wb_data,
    input  logic                   alu_ready,
    input  logic                   lsu_ready,
    output logic                   alu_valid,
    output logic                   lsu_valid,
    output logic [3:0]             disp_op,
    output issue_pkg::reg_idx_t    disp_rd,
    output logic                   disp_wb,
    output logic [`ISSUE_XLEN-1:0] disp_rs1_data,
    output logic [`ISSUE_XLEN-1:0] disp_rs2_data,
    output logic [`ISSUE_XLEN-1:0] disp_imm
);
    import issue_pkg::*;

    logic                   ibuf_valid;
    logic                   ibuf_ready;
    instr_t                 ibuf_instr;
    logic                   sb_valid;
    logic                   sb_ready;
    instr_t                 sb_instr;
    logic                   opd_valid;
    logic                   opd_ready;
    instr_t                 opd_instr;
    logic [`ISSUE_XLEN-1:0] opd_rs1_data;
    logic [`ISSUE_XLEN-1:0] opd_rs2_data;

    issue_ibuffer ibuffer (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .decode_valid (decode_valid),
        .decode_instr (decode_instr),
        .decode_ready (decode_ready),
        .ibuf_valid   (ibuf_valid),
        .ibuf_instr   (ibuf_instr),
        .ibuf_ready   (ibuf_ready)
    );

    issue_scoreboard scoreboard (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .ibuf_valid (ibuf_valid),
        .ibuf_instr (ibuf_instr),
        .ibuf_ready (ibuf_ready),
        .sb_valid   (sb_valid),
        .sb_instr   (sb_instr),
        .sb_ready   (sb_ready),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd)
    );

    issue_operands operands (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .sb_valid     (sb_valid),
        .sb_instr     (sb_instr),
        .sb_ready     (sb_ready),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .opd_valid    (opd_valid),
        .opd_instr    (opd_instr),
        .opd_rs1_data (opd_rs1_data),
        .opd_rs2_data (opd_rs2_data),
        .opd_ready    (opd_ready)
    );

    issue_dispatch dispatch (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .opd_valid     (opd_valid),
        .opd_instr     (opd_instr),
        .opd_rs1_data  (opd_rs1_data),
        .opd_rs2_data  (opd_rs2_data),
        .opd_ready     (opd_ready),
        .alu_ready     (alu_ready),
        .lsu_ready     (lsu_ready),
        .alu_valid     (alu_valid),
        .lsu_valid     (lsu_valid),
        .disp_op       (disp_op),
        .disp_rd       (disp_rd),
        .disp_wb       (disp_wb),
        .disp_rs1_data (disp_rs1_data),
        .disp_rs2_data (disp_rs2_data),
        .disp_imm      (disp_imm)
    );

endmodule

//--- dv/issue_checker.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input logic                   decode_valid,
    input logic                   decode_ready,
    input logic                   ibuf_valid,
    input logic                   ibuf_ready,
    input logic                   alu_valid,
    input logic                   alu_ready,
    input logic                   lsu_valid,
    input logic                   lsu_ready,
    input logic [3:0]             disp_op,
    input issue_pkg::reg_idx_t    disp_rd,
    input logic                   disp_wb,
    input logic [`ISSUE_XLEN-1:0] disp_rs1_data,
    input logic [`ISSUE_XLEN-1:0] disp_rs2_data,
    input logic [`ISSUE_XLEN-1:0] disp_imm
);
    int   occupancy;
    logic reset_bad = 1'b0;
    logic overlap_bad = 1'b0;
    logic hold_bad = 1'b0;
    logic full_bad = 1'b0;
    logic failed;

    assign failed = reset_bad || overlap_bad || hold_bad || full_bad;

    // Entries held in the instruction buffer, counted from its two handshakes
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(decode_valid && decode_ready)
                       - int'(ibuf_valid && ibuf_ready);
        end
    end

    reset_state: assert property (@(posedge clk)
        reset |=> !alu_valid && !lsu_valid && decode_ready)
        else begin
            $error("dispatch valid high or decode_ready low after reset");
            reset_bad = 1'b1;
        end

    one_unit: assert property (@(posedge clk) disable iff (reset)
        !(alu_valid && lsu_valid))
        else begin
            $error("alu_valid and lsu_valid high together");
            overlap_bad = 1'b1;
        end

    // A stalled dispatch keeps its valid and its data until the unit takes it
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        ((alu_valid && !alu_ready) || (lsu_valid && !lsu_ready)) && !flush |=>
            $stable({alu_valid, lsu_valid, disp_op, disp_rd, disp_wb,
                     disp_rs1_data, disp_rs2_data, disp_imm}))
        else begin
            $error("stalled dispatch changed before its transfer");
            hold_bad = 1'b1;
        end

    full_stall: assert property (@(posedge clk) disable iff (reset)
        decode_ready == (occupancy != `ISSUE_IBUF_DEPTH))
        else begin
            $error("decode_ready does not match the buffer occupancy");
            full_bad = 1'b1;
        end

endmodule

//--- dv/issue_tb.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int XLEN        = `ISSUE_XLEN;
    localparam int NUM_INSTR   = 200;
    localparam int MAX_DELAY   = 6;
    localparam int TIMEOUT     = NUM_INSTR * (`ISSUE_IBUF_DEPTH + 8 + MAX_DELAY);
    localparam int FLUSH_IDLE  = 0;
    localparam int FLUSH_ON    = 1;
    localparam int FLUSH_DRAIN = 2;
    localparam int FLUSH_DONE  = 3;

    logic            clk;
    logic            reset;
    logic            flush;
    logic            decode_valid;
    instr_t          decode_instr;
    logic            decode_ready;
    logic            wb_valid;
    reg_idx_t        wb_rd;
    logic [XLEN-1:0] wb_data;
    logic            alu_ready;
    logic            lsu_ready;
    logic            alu_valid;
    logic            lsu_valid;
    logic [3:0]      disp_op;
    reg_idx_t        disp_rd;
    logic            disp_wb;
    logic [XLEN-1:0] disp_rs1_data;
    logic [XLEN-1:0] disp_rs2_data;
    logic [XLEN-1:0] disp_imm;

    // Reference model with the register values and the in-order queues
    logic [XLEN-1:0] regs [`ISSUE_NUM_REGS];
    instr_t          expect_q [$];
    reg_idx_t        wb_rd_q [$];
    int              wb_due_q [$];
    int              accepted;
    int              step;
    int              flush_state;
    int              cycles = 0;

    issue_top dut (.*);

    bind issue_top issue_checker protocol_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string test, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        assert (actual == expected) else begin
            $display("error %s expected %0h actual %0h", test, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [XLEN-1:0] model_read(input reg_idx_t idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    // True when an earlier dispatched instruction still owes this register a writeback
    function automatic logic waits_for_wb(input reg_idx_t idx);
        logic found;
        found = 1'b0;
        foreach (wb_rd_q[i]) begin
            if (idx != '0 && wb_rd_q[i] == idx) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Small register range so that hazards show up often
    function automatic instr_t random_instr();
        instr_t w;
        w = '0;
        w.reg_form.ex_type = ($urandom_range(0, 1) == 0) ? EX_ALU : EX_LSU;
        w.reg_form.use_imm = ($urandom_range(0, 1) == 1);
        w.reg_form.op      = 4'($urandom());
        w.reg_form.rd      = reg_idx_t'($urandom_range(0, 15));
        w.reg_form.wb      = ($urandom_range(0, 3) != 0);
        w.reg_form.rs1     = reg_idx_t'($urandom_range(0, 15));
        if (w.reg_form.use_imm) begin
            w.imm_form.imm = 15'($urandom());
        end else begin
            w.reg_form.rs2 = reg_idx_t'($urandom_range(0, 15));
        end
        return w;
    endfunction

    task automatic check_dispatch();
        instr_t          head;
        logic [XLEN-1:0] imm_exp;
        logic [XLEN-1:0] rs2_exp;
        assert (expect_q.size() != 0) else begin
            $display("an instruction was dispatched when none was expected");
            abort_run();
        end
        head = expect_q.pop_front();
        // The immediate field is a signed value widened to the data width
        if (head.reg_form.use_imm) begin
            imm_exp = XLEN'($signed(head.imm_form.imm));
        end else begin
            imm_exp = '0;
        end
        rs2_exp = head.reg_form.use_imm ? '0 : model_read(head.reg_form.rs2);
        check_value("route_lsu", XLEN'(head.reg_form.ex_type == EX_LSU), XLEN'(lsu_valid));
        check_value("order_op", XLEN'(head.reg_form.op), XLEN'(disp_op));
        check_value("order_rd", XLEN'(head.reg_form.rd), XLEN'(disp_rd));
        check_value("order_wb", XLEN'(head.reg_form.wb), XLEN'(disp_wb));
        check_value("operand_rs1", model_read(head.reg_form.rs1), disp_rs1_data);
        check_value("operand_rs2", rs2_exp, disp_rs2_data);
        check_value("operand_imm", imm_exp, disp_imm);
        assert (!waits_for_wb(head.reg_form.rs1)
                && !(!head.reg_form.use_imm && waits_for_wb(head.reg_form.rs2))
                && !(head.reg_form.wb && waits_for_wb(head.reg_form.rd))) else begin
            $display("an instruction was dispatched while its registers wait for a writeback");
            abort_run();
        end
        if (head.reg_form.wb && head.reg_form.rd != '0) begin
            wb_rd_q.push_back(head.reg_form.rd);
            wb_due_q.push_back(step + int'($urandom_range(1, MAX_DELAY)));
        end
    endtask

    initial begin
        reg_idx_t        rd;
        logic [XLEN-1:0] data;
        logic            decode_busy;
        void'($urandom(32'hbcc7));
        reset        <= 1'b1;
        flush        <= 1'b0;
        decode_valid <= 1'b0;
        decode_instr <= '0;
        wb_valid     <= 1'b0;
        wb_rd        <= '0;
        wb_data      <= '0;
        alu_ready    <= 1'b0;
        lsu_ready    <= 1'b0;
        accepted    = 0;
        step        = 0;
        flush_state = FLUSH_IDLE;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (!(accepted == NUM_INSTR && expect_q.size() == 0 && wb_rd_q.size() == 0
                 && flush_state == FLUSH_DONE)) begin
            // Transfers are decided here for the coming edge
            @(negedge clk);
            decode_busy = decode_valid && !decode_ready;
            if (decode_valid && decode_ready) begin
                expect_q.push_back(decode_instr);
                accepted++;
            end
            if ((alu_valid && alu_ready) || (lsu_valid && lsu_ready)) begin
                check_dispatch();
            end
            // Everything still held in the DUT is dropped by the flush at this edge
            if (flush_state == FLUSH_ON) begin
                expect_q.delete();
                flush_state = FLUSH_DRAIN;
            end
            @(posedge clk);
            step++;
            if (wb_rd_q.size() != 0 && wb_due_q[0] <= step) begin
                rd = wb_rd_q.pop_front();
                void'(wb_due_q.pop_front());
                data     = $urandom();
                regs[rd] = data;
                wb_valid <= 1'b1;
                wb_rd    <= rd;
                wb_data  <= data;
            end else begin
                wb_valid <= 1'b0;
            end
            // New decodes wait until the writebacks from before the flush are back
            if (flush_state == FLUSH_DRAIN && wb_rd_q.size() == 0) begin
                flush_state = FLUSH_DONE;
            end
            flush     <= 1'b0;
            alu_ready <= ($urandom_range(0, 3) != 0);
            lsu_ready <= ($urandom_range(0, 3) != 0);
            if (!decode_busy) begin
                if (flush_state == FLUSH_IDLE && accepted >= NUM_INSTR / 2) begin
                    decode_valid <= 1'b0;
                    flush        <= 1'b1;
                    flush_state = FLUSH_ON;
                end else if ((flush_state == FLUSH_IDLE || flush_state == FLUSH_DONE)
                             && accepted < NUM_INSTR && $urandom_range(0, 3) != 0) begin
                    decode_valid <= 1'b1;
                    decode_instr <= random_instr();
                end else begin
                    decode_valid <= 1'b0;
                end
            end
        end
        @(negedge clk);
        if (dut.protocol_checker.failed) begin
            $display("a protocol assertion in the checker failed");
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            cycles++;
            if (dut.protocol_checker.failed) begin
                $display("a protocol assertion in the checker failed");
                abort_run();
            end else if (cycles > TIMEOUT) begin
                $display("the run did not finish within %0d cycles", TIMEOUT);
                abort_run();
            end
        end
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_ibuffer.sv
rtl/issue_scoreboard.sv
rtl/issue_operands.sv
rtl/issue_dispatch.sv
rtl/issue_top.sv
dv/issue_checker.sv
dv/issue_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, the log decides the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
